// ==== project.f ====
wb_bus_pkg.sv
wb_map_pkg.sv
wb_mst_if.sv
wb_master_route.sv
wb_target_port.sv
wb_xbar_top.sv
wb_xbar_chk.sv
tb_wb_xbar_top.sv

// ==== tb_wb_xbar_top.sv ====
`timescale 1ns/1ps

module tb_wb_xbar_top;

  localparam int N_MST   = 3;
  localparam int TIMEOUT = 200;
  localparam int N_RAND  = 40;

  // Read-back pattern of a word that was never written
  localparam logic [31:0] FILL_XOR = 32'hA5A5_0000;

  logic clk;
  logic arst_n;

  // One slot per master on the master side
  wb_bus_pkg::wb_adr_t  m_adr  [N_MST];
  wb_bus_pkg::wb_data_t m_wdat [N_MST];
  wb_bus_pkg::wb_sel_t  m_sel  [N_MST];
  logic                 m_we   [N_MST];
  logic                 m_cyc  [N_MST];
  logic                 m_stb  [N_MST];
  wb_bus_pkg::wb_data_t m_rdat [N_MST];
  logic                 m_ack  [N_MST];

  // Slave side with index 0 for s0 and index 1 for s1
  wb_bus_pkg::wb_adr_t  s0_adr;
  logic [7:0]           s1_adr;
  wb_bus_pkg::wb_adr_t  s_adr  [2];
  wb_bus_pkg::wb_data_t s_wdat [2];
  wb_bus_pkg::wb_sel_t  s_sel  [2];
  logic                 s_we   [2];
  logic                 s_cyc  [2];
  logic                 s_stb  [2];
  wb_bus_pkg::wb_data_t s_rdat [2];
  logic                 s_ack  [2];

  // Last access seen by each slave model
  wb_bus_pkg::wb_adr_t  rec_adr  [2];
  wb_bus_pkg::wb_data_t rec_wdat [2];
  wb_bus_pkg::wb_sel_t  rec_sel  [2];
  logic                 rec_we   [2];
  logic                 rec_new  [2];

  // Order of accesses on s0
  wb_bus_pkg::wb_adr_t  s0_log_q [$];

  // Slave memories and reference model, keyed by target and slave address
  wb_bus_pkg::wb_data_t slv_mem [logic [32:0]];
  wb_bus_pkg::wb_data_t ref_mem [logic [32:0]];

  // Set once both slaves were seen in a cycle at the same time
  logic both_cyc = 1'b0;

  assign s_adr[0] = s0_adr;
  assign s_adr[1] = {24'h0, s1_adr};

  wb_xbar_top u_wb_xbar_top (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .m0_wbd_adr_i (m_adr[0]),
    .m0_wbd_dat_i (m_wdat[0]),
    .m0_wbd_sel_i (m_sel[0]),
    .m0_wbd_we_i  (m_we[0]),
    .m0_wbd_cyc_i (m_cyc[0]),
    .m0_wbd_stb_i (m_stb[0]),
    .m0_wbd_dat_o (m_rdat[0]),
    .m0_wbd_ack_o (m_ack[0]),
    .m1_wbd_adr_i (m_adr[1]),
    .m1_wbd_dat_i (m_wdat[1]),
    .m1_wbd_sel_i (m_sel[1]),
    .m1_wbd_we_i  (m_we[1]),
    .m1_wbd_cyc_i (m_cyc[1]),
    .m1_wbd_stb_i (m_stb[1]),
    .m1_wbd_dat_o (m_rdat[1]),
    .m1_wbd_ack_o (m_ack[1]),
    .m2_wbd_adr_i (m_adr[2]),
    .m2_wbd_dat_i (m_wdat[2]),
    .m2_wbd_sel_i (m_sel[2]),
    .m2_wbd_we_i  (m_we[2]),
    .m2_wbd_cyc_i (m_cyc[2]),
    .m2_wbd_stb_i (m_stb[2]),
    .m2_wbd_dat_o (m_rdat[2]),
    .m2_wbd_ack_o (m_ack[2]),
    .s0_wbd_adr_o (s0_adr),
    .s0_wbd_dat_o (s_wdat[0]),
    .s0_wbd_sel_o (s_sel[0]),
    .s0_wbd_we_o  (s_we[0]),
    .s0_wbd_cyc_o (s_cyc[0]),
    .s0_wbd_stb_o (s_stb[0]),
    .s0_wbd_dat_i (s_rdat[0]),
    .s0_wbd_ack_i (s_ack[0]),
    .s1_wbd_adr_o (s1_adr),
    .s1_wbd_dat_o (s_wdat[1]),
    .s1_wbd_sel_o (s_sel[1]),
    .s1_wbd_we_o  (s_we[1]),
    .s1_wbd_cyc_o (s_cyc[1]),
    .s1_wbd_stb_o (s_stb[1]),
    .s1_wbd_dat_i (s_rdat[1]),
    .s1_wbd_ack_i (s_ack[1])
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Mid-cycle look at both slave ports
  always @(negedge clk) begin
    if (s_cyc[0] && s_cyc[1]) begin
      both_cyc <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  // Target picked by the address map
  function automatic wb_map_pkg::tgt_id_t exp_tgt(input wb_bus_pkg::wb_adr_t adr);
    wb_map_pkg::tgt_id_t id;
    // Flash window, register page and unmapped space all stay on s0
    id = wb_map_pkg::TGT_MEM;
    if ((adr[31:28] != wb_map_pkg::REGION_MEM) &&
        ((adr[31:16] == wb_map_pkg::PAGE_UART) || (adr[31:16] == wb_map_pkg::PAGE_PINMUX))) begin
      id = wb_map_pkg::TGT_PERI;
    end
    return id;
  endfunction

  // Address as the target slave sees it
  function automatic wb_bus_pkg::wb_adr_t slave_view(input wb_bus_pkg::wb_adr_t adr);
    return (exp_tgt(adr) == wb_map_pkg::TGT_PERI) ? {24'h0, adr[7:0]} : adr;
  endfunction

  // Byte-lane write into an old word
  function automatic wb_bus_pkg::wb_data_t merge_bytes(input wb_bus_pkg::wb_data_t old,
                                                       input wb_bus_pkg::wb_data_t wdat,
                                                       input wb_bus_pkg::wb_sel_t  sel);
    wb_bus_pkg::wb_data_t res;
    res = old;
    for (int b = 0; b < wb_bus_pkg::SEL_W; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = wdat[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Mapped pages plus unmapped space in a small word window so reads hit writes
  function automatic wb_bus_pkg::wb_adr_t rand_adr();
    wb_bus_pkg::wb_adr_t offs;
    wb_bus_pkg::wb_adr_t hi;
    wb_bus_pkg::wb_adr_t adr;
    offs = wb_bus_pkg::wb_adr_t'($urandom_range(15, 0) * 4);
    // Random bits above the low byte exercise peripheral aliasing
    hi   = wb_bus_pkg::wb_adr_t'($urandom_range(255, 0)) << 8;
    case ($urandom_range(5, 0))
      0:       adr = 32'h0000_0000 | offs;
      1:       adr = 32'h1000_0000 | offs;
      2:       adr = 32'h1001_0000 | hi | offs;
      3:       adr = 32'h1002_0000 | hi | offs;
      4:       adr = 32'h1003_0000 | offs;
      default: adr = 32'hF000_0000 | offs;
    endcase
    return adr;
  endfunction

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------

  task automatic check_data(input string name, input wb_bus_pkg::wb_data_t exp,
                            input wb_bus_pkg::wb_data_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_adr(input string name, input wb_bus_pkg::wb_adr_t exp,
                           input wb_bus_pkg::wb_adr_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
      $display("Checks failed");
      $fatal(1, "bit mismatch");
    end
  endtask

  // ----------------------------------------------------------------------
  // Slave and master models
  // ----------------------------------------------------------------------

  // Answers after 0 to 4 wait cycles with ack held for one cycle
  task automatic serve_slave(input int t);
    logic [32:0]          key;
    wb_bus_pkg::wb_data_t word;
    forever begin
      @(negedge clk);
      if (s_cyc[t] && s_stb[t]) begin
        key        = {t[0], s_adr[t]};
        word       = slv_mem.exists(key) ? slv_mem[key] : (s_adr[t] ^ FILL_XOR);
        rec_adr[t]  = s_adr[t];
        rec_wdat[t] = s_wdat[t];
        rec_sel[t]  = s_sel[t];
        rec_we[t]   = s_we[t];
        rec_new[t]  = 1'b1;
        if (t == 0) begin
          s0_log_q.push_back(s_adr[t]);
        end
        repeat ($urandom_range(4, 0)) @(posedge clk);
        @(posedge clk);
        #1;
        s_ack[t]  = 1'b1;
        s_rdat[t] = word;
        if (s_we[t]) begin
          slv_mem[key] = merge_bytes(word, s_wdat[t], s_sel[t]);
        end
        @(posedge clk);
        #1;
        s_ack[t] = 1'b0;
      end
    end
  endtask

  // One Wishbone access by master i checked against the model on its ack
  task automatic do_access(input int i, input logic we, input wb_bus_pkg::wb_adr_t adr,
                           input wb_bus_pkg::wb_data_t wdat, input wb_bus_pkg::wb_sel_t sel,
                           output wb_bus_pkg::wb_data_t rdat);
    wb_map_pkg::tgt_id_t  tgt;
    logic [32:0]          key;
    wb_bus_pkg::wb_data_t exp_word;
    int                   cycles;
    string                name;
    tgt  = exp_tgt(adr);
    key  = {tgt, slave_view(adr)};
    name = $sformatf("m%0d %s %h", i, we ? "write" : "read", adr);
    @(posedge clk);
    #1;
    m_adr[i]  = adr;
    m_wdat[i] = wdat;
    m_sel[i]  = sel;
    m_we[i]   = we;
    m_cyc[i]  = 1'b1;
    m_stb[i]  = 1'b1;
    cycles    = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!m_ack[i] && (cycles < TIMEOUT));
    if (!m_ack[i]) begin
      $display("Master %0d got no ack within %0d cycles for %s", i, TIMEOUT, name);
      $display("Checks failed");
      $fatal(1, "ack timeout");
    end
    rdat     = m_rdat[i];
    exp_word = ref_mem.exists(key) ? ref_mem[key] : (slave_view(adr) ^ FILL_XOR);
    // Access must have landed on the decoded target with the master's fields
    check_bit({name, " target"}, 1'b1, rec_new[tgt]);
    rec_new[tgt] = 1'b0;
    check_adr({name, " slave adr"}, slave_view(adr), rec_adr[tgt]);
    check_bit({name, " we"}, we, rec_we[tgt]);
    check_data({name, " sel"}, wb_bus_pkg::wb_data_t'(sel),
               wb_bus_pkg::wb_data_t'(rec_sel[tgt]));
    if (we) begin
      check_data({name, " wdat"}, wdat, rec_wdat[tgt]);
      ref_mem[key] = merge_bytes(exp_word, wdat, sel);
    end else begin
      check_data({name, " rdat"}, exp_word, rdat);
    end
    @(posedge clk);
    #1;
    m_cyc[i] = 1'b0;
    m_stb[i] = 1'b0;
  endtask

  // Random reads and writes from one master
  task automatic run_master(input int i);
    wb_bus_pkg::wb_data_t rdat;
    repeat (N_RAND) begin
      do_access(i, 1'($urandom_range(1, 0)), rand_adr(), $urandom(),
                wb_bus_pkg::wb_sel_t'($urandom_range(15, 1)), rdat);
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    wb_bus_pkg::wb_data_t rdat [N_MST];
    wb_bus_pkg::wb_data_t wval;
    int unsigned          chk_fails;
    void'($urandom(59829));
    arst_n = 1'b0;
    for (int i = 0; i < N_MST; i++) begin
      m_adr[i]  = '0;
      m_wdat[i] = '0;
      m_sel[i]  = '0;
      m_we[i]   = 1'b0;
      m_cyc[i]  = 1'b0;
      m_stb[i]  = 1'b0;
    end
    for (int t = 0; t < 2; t++) begin
      s_ack[t]   = 1'b0;
      s_rdat[t]  = '0;
      rec_new[t] = 1'b0;
    end
    fork
      serve_slave(0);
      serve_slave(1);
    join_none
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Idle bus after reset
    @(negedge clk);
    for (int i = 0; i < N_MST; i++) begin
      check_bit($sformatf("reset m%0d ack", i), 1'b0, m_ack[i]);
    end
    for (int t = 0; t < 2; t++) begin
      check_bit($sformatf("reset s%0d cyc", t), 1'b0, s_cyc[t]);
      check_bit($sformatf("reset s%0d stb", t), 1'b0, s_stb[t]);
    end

    // All masters on s0 at once and m0 asks again while m2 still waits
    // Round robin serves m2 before the second m0 access
    fork
      begin
        do_access(0, 1'b0, 32'h0000_0100, '0, 4'hF, rdat[0]);
        do_access(0, 1'b0, 32'h0000_010C, '0, 4'hF, rdat[0]);
      end
      do_access(1, 1'b0, 32'h0000_0104, '0, 4'hF, rdat[1]);
      do_access(2, 1'b0, 32'h0000_0108, '0, 4'hF, rdat[2]);
    join
    check_data("rr access count", 32'd4, wb_bus_pkg::wb_data_t'(s0_log_q.size()));
    for (int i = 0; i < 4; i++) begin
      check_adr($sformatf("rr order slot %0d", i), 32'h0000_0100 + 4 * i, s0_log_q[i]);
    end

    // Two targets in flight together
    fork
      do_access(0, 1'b1, 32'h1000_0010, 32'h1234_5678, 4'hF, rdat[0]);
      do_access(1, 1'b0, 32'h1001_0020, '0, 4'hF, rdat[1]);
    join
    check_bit("s0 and s1 cyc overlap", 1'b1, both_cyc);

    // UART and pin-mux addresses with equal low byte share one register
    wval = $urandom();
    do_access(2, 1'b1, 32'h1001_0044, wval, 4'hF, rdat[2]);
    do_access(0, 1'b0, 32'h1002_5544, '0, 4'hF, rdat[0]);
    check_data("peri low byte alias", wval, rdat[0]);

    // Random traffic from all masters
    fork
      run_master(0);
      run_master(1);
      run_master(2);
    join

    chk_fails = u_wb_xbar_top.u_port_mem.u_chk.fail_cnt +
                u_wb_xbar_top.u_port_peri.u_chk.fail_cnt;
    if (chk_fails == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("%0d target port assertions failed", chk_fails);
      $display("Checks failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// ==== wb_xbar_chk.sv ====
`timescale 1ns/1ps

module wb_xbar_chk #(
  parameter int N_MST = 3
) (
  input logic             clk_i,
  input logic             arst_n_i,
  input logic [N_MST-1:0] req_i,
  input logic [N_MST-1:0] ack_o,
  input logic             s_cyc_o,
  input logic             s_stb_o
);

  // Count of failed assertions in this port
  int unsigned fail_cnt = 0;

  // Any request since the last reset
  logic seen_req_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      seen_req_q <= 1'b0;
    end else if (|req_i) begin
      seen_req_q <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Port properties
  // ----------------------------------------------------------------------

  // At most one master acked
  a_ack_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(ack_o))
    else begin
      $error("ack_o has more than one bit set");
      fail_cnt++;
    end

  // Strobe only inside a cycle
  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s_stb_o |-> s_cyc_o)
    else begin
      $error("s_stb_o high while s_cyc_o low");
      fail_cnt++;
    end

  // Ack is a single-cycle pulse
  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ack_o != '0) |=> (ack_o == '0))
    else begin
      $error("ack_o held for more than one cycle");
      fail_cnt++;
    end

  // No ack out of reset before any master asked
  a_no_early_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !seen_req_q |-> (ack_o == '0))
    else begin
      $error("ack_o raised before any request");
      fail_cnt++;
    end

endmodule

// Attached to both target ports
bind wb_target_port wb_xbar_chk #(.N_MST(N_MST)) u_chk (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .req_i    (req_i),
  .ack_o    (ack_o),
  .s_cyc_o  (s_cyc_o),
  .s_stb_o  (s_stb_o)
);

// ==== wb_xbar_top.sv ====
`timescale 1ns/1ps

module wb_xbar_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // Master 0, external host
  input  wb_bus_pkg::wb_adr_t   m0_wbd_adr_i,
  input  wb_bus_pkg::wb_data_t  m0_wbd_dat_i,
  input  wb_bus_pkg::wb_sel_t   m0_wbd_sel_i,
  input  logic                  m0_wbd_we_i,
  input  logic                  m0_wbd_cyc_i,
  input  logic                  m0_wbd_stb_i,
  output wb_bus_pkg::wb_data_t  m0_wbd_dat_o,
  output logic                  m0_wbd_ack_o,

  // Master 1, instruction fetch
  input  wb_bus_pkg::wb_adr_t   m1_wbd_adr_i,
  input  wb_bus_pkg::wb_data_t  m1_wbd_dat_i,
  input  wb_bus_pkg::wb_sel_t   m1_wbd_sel_i,
  input  logic                  m1_wbd_we_i,
  input  logic                  m1_wbd_cyc_i,
  input  logic                  m1_wbd_stb_i,
  output wb_bus_pkg::wb_data_t  m1_wbd_dat_o,
  output logic                  m1_wbd_ack_o,

  // Master 2, data
  input  wb_bus_pkg::wb_adr_t   m2_wbd_adr_i,
  input  wb_bus_pkg::wb_data_t  m2_wbd_dat_i,
  input  wb_bus_pkg::wb_sel_t   m2_wbd_sel_i,
  input  logic                  m2_wbd_we_i,
  input  logic                  m2_wbd_cyc_i,
  input  logic                  m2_wbd_stb_i,
  output wb_bus_pkg::wb_data_t  m2_wbd_dat_o,
  output logic                  m2_wbd_ack_o,

  // Slave 0, flash memory and its registers
  output wb_bus_pkg::wb_adr_t   s0_wbd_adr_o,
  output wb_bus_pkg::wb_data_t  s0_wbd_dat_o,
  output wb_bus_pkg::wb_sel_t   s0_wbd_sel_o,
  output logic                  s0_wbd_we_o,
  output logic                  s0_wbd_cyc_o,
  output logic                  s0_wbd_stb_o,
  input  wb_bus_pkg::wb_data_t  s0_wbd_dat_i,
  input  logic                  s0_wbd_ack_i,

  // Slave 1, UART and pin-mux, low address byte only
  output logic [7:0]            s1_wbd_adr_o,
  output wb_bus_pkg::wb_data_t  s1_wbd_dat_o,
  output wb_bus_pkg::wb_sel_t   s1_wbd_sel_o,
  output logic                  s1_wbd_we_o,
  output logic                  s1_wbd_cyc_o,
  output logic                  s1_wbd_stb_o,
  input  wb_bus_pkg::wb_data_t  s1_wbd_dat_i,
  input  logic                  s1_wbd_ack_i
);

  localparam int N_MST      = 3;
  localparam int PERI_ADR_W = 8;

  // Router to port requests and port to router responses
  logic [N_MST-1:0]                 req_mem;
  logic [N_MST-1:0]                 req_peri;
  logic [N_MST-1:0]                 ack_mem;
  logic [N_MST-1:0]                 ack_peri;
  wb_bus_pkg::wb_data_t             rdat_mem;
  wb_bus_pkg::wb_data_t             rdat_peri;
  logic [N_MST-1:0]                 mst_ack;
  wb_bus_pkg::wb_data_t [N_MST-1:0] mst_dat;

  // ----------------------------------------------------------------------
  // Master request bundle
  // ----------------------------------------------------------------------

  wb_mst_if #(.N_MST(N_MST)) u_mst_if ();

  // Highest master in the top slot
  assign u_mst_if.adr  = {m2_wbd_adr_i, m1_wbd_adr_i, m0_wbd_adr_i};
  assign u_mst_if.wdat = {m2_wbd_dat_i, m1_wbd_dat_i, m0_wbd_dat_i};
  assign u_mst_if.sel  = {m2_wbd_sel_i, m1_wbd_sel_i, m0_wbd_sel_i};
  assign u_mst_if.we   = {m2_wbd_we_i,  m1_wbd_we_i,  m0_wbd_we_i};
  assign u_mst_if.cyc  = {m2_wbd_cyc_i, m1_wbd_cyc_i, m0_wbd_cyc_i};
  assign u_mst_if.stb  = {m2_wbd_stb_i, m1_wbd_stb_i, m0_wbd_stb_i};

  // ----------------------------------------------------------------------
  // Decode and response routing
  // ----------------------------------------------------------------------

  wb_master_route #(.N_MST(N_MST)) u_route (
    .mst         (u_mst_if.snk),
    .req_mem_o   (req_mem),
    .req_peri_o  (req_peri),
    .ack_mem_i   (ack_mem),
    .ack_peri_i  (ack_peri),
    .rdat_mem_i  (rdat_mem),
    .rdat_peri_i (rdat_peri),
    .mst_ack_o   (mst_ack),
    .mst_dat_o   (mst_dat)
  );

  assign m0_wbd_ack_o = mst_ack[0];
  assign m1_wbd_ack_o = mst_ack[1];
  assign m2_wbd_ack_o = mst_ack[2];
  assign m0_wbd_dat_o = mst_dat[0];
  assign m1_wbd_dat_o = mst_dat[1];
  assign m2_wbd_dat_o = mst_dat[2];

  // ----------------------------------------------------------------------
  // Target ports, running side by side
  // ----------------------------------------------------------------------

  wb_target_port #(.N_MST(N_MST), .TGT_ADR_W(wb_bus_pkg::ADR_W)) u_port_mem (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .mst      (u_mst_if.snk),
    .req_i    (req_mem),
    .ack_o    (ack_mem),
    .rdat_o   (rdat_mem),
    .s_adr_o  (s0_wbd_adr_o),
    .s_dat_o  (s0_wbd_dat_o),
    .s_sel_o  (s0_wbd_sel_o),
    .s_we_o   (s0_wbd_we_o),
    .s_cyc_o  (s0_wbd_cyc_o),
    .s_stb_o  (s0_wbd_stb_o),
    .s_dat_i  (s0_wbd_dat_i),
    .s_ack_i  (s0_wbd_ack_i)
  );

  // Peripheral registers alias on the low address byte
  wb_target_port #(.N_MST(N_MST), .TGT_ADR_W(PERI_ADR_W)) u_port_peri (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .mst      (u_mst_if.snk),
    .req_i    (req_peri),
    .ack_o    (ack_peri),
    .rdat_o   (rdat_peri),
    .s_adr_o  (s1_wbd_adr_o),
    .s_dat_o  (s1_wbd_dat_o),
    .s_sel_o  (s1_wbd_sel_o),
    .s_we_o   (s1_wbd_we_o),
    .s_cyc_o  (s1_wbd_cyc_o),
    .s_stb_o  (s1_wbd_stb_o),
    .s_dat_i  (s1_wbd_dat_i),
    .s_ack_i  (s1_wbd_ack_i)
  );

endmodule

// ==== wb_target_port.sv ====
`timescale 1ns/1ps

module wb_target_port #(
  parameter int N_MST     = 3,
  parameter int TGT_ADR_W = 32
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // Request fields of all masters
  wb_mst_if.snk                 mst,

  // Decoded requests aimed at this target
  input  logic [N_MST-1:0]      req_i,

  // One-cycle ack to the granted master and captured read data
  output logic [N_MST-1:0]      ack_o,
  output wb_bus_pkg::wb_data_t  rdat_o,

  // Slave side, all from registers
  output logic [TGT_ADR_W-1:0]  s_adr_o,
  output wb_bus_pkg::wb_data_t  s_dat_o,
  output wb_bus_pkg::wb_sel_t   s_sel_o,
  output logic                  s_we_o,
  output logic                  s_cyc_o,
  output logic                  s_stb_o,
  input  wb_bus_pkg::wb_data_t  s_dat_i,
  input  logic                  s_ack_i
);

  // Width of a master index
  localparam int IDX_W = (N_MST > 1) ? $clog2(N_MST) : 1;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_ACK  = 2'd2
  } port_state_t;

  port_state_t      state_q;

  // Granted master, also the round-robin pointer
  logic [IDX_W-1:0] gnt_q;

  // Next winner as seen from the current pointer
  logic [IDX_W-1:0] nxt_idx;
  logic             nxt_found;

  // Grant and completion strobes
  logic             grant_go;
  logic             done_go;

  // ----------------------------------------------------------------------
  // Round-robin pick
  // ----------------------------------------------------------------------

  // Scan starts one past the last granted master and wraps
  always_comb begin
    int unsigned cand;
    nxt_found = 1'b0;
    nxt_idx   = gnt_q;
    for (int k = 1; k <= N_MST; k++) begin
      cand = (int'(gnt_q) + k) % N_MST;
      if (!nxt_found && req_i[cand]) begin
        nxt_found = 1'b1;
        nxt_idx   = IDX_W'(cand);
      end
    end
  end

  // Only IDLE arbitrates, ACK waits for the master to drop stb
  assign grant_go = (state_q == ST_IDLE) && nxt_found;

  // First slave ack ends the access
  assign done_go  = (state_q == ST_BUSY) && s_ack_i;

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      // Pointer on the last master so m0 wins first
      gnt_q   <= IDX_W'(N_MST - 1);
      s_cyc_o <= 1'b0;
      s_stb_o <= 1'b0;
      ack_o   <= '0;
    end else begin
      // Ack is a single-cycle pulse
      ack_o <= '0;
      case (state_q)
        ST_IDLE: begin
          if (grant_go) begin
            state_q <= ST_BUSY;
            gnt_q   <= nxt_idx;
            s_cyc_o <= 1'b1;
            s_stb_o <= 1'b1;
          end
        end
        ST_BUSY: begin
          if (done_go) begin
            state_q      <= ST_ACK;
            s_cyc_o      <= 1'b0;
            s_stb_o      <= 1'b0;
            ack_o[gnt_q] <= 1'b1;
          end
        end
        ST_ACK: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Staging registers
  // ----------------------------------------------------------------------

  // Winner's fields held toward the slave for the whole access
  always_ff @(posedge clk_i) begin
    if (grant_go) begin
      s_adr_o <= mst.adr[nxt_idx][TGT_ADR_W-1:0];
      s_dat_o <= mst.wdat[nxt_idx];
      s_sel_o <= mst.sel[nxt_idx];
      s_we_o  <= mst.we[nxt_idx];
    end
    // Read data captured on the same edge as the slave ack
    if (done_go) begin
      rdat_o <= s_dat_i;
    end
  end

endmodule

// ==== wb_master_route.sv ====
`timescale 1ns/1ps

module wb_master_route #(
  parameter int N_MST = 3
) (
  // Master request fields
  wb_mst_if.snk                     mst,

  // Requests toward each target
  output logic [N_MST-1:0]          req_mem_o,
  output logic [N_MST-1:0]          req_peri_o,

  // Responses from each target
  input  logic [N_MST-1:0]          ack_mem_i,
  input  logic [N_MST-1:0]          ack_peri_i,
  input  wb_bus_pkg::wb_data_t      rdat_mem_i,
  input  wb_bus_pkg::wb_data_t      rdat_peri_i,

  // Responses back to the masters
  output logic [N_MST-1:0]          mst_ack_o,
  output wb_bus_pkg::wb_data_t [N_MST-1:0] mst_dat_o
);

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------

  // Decoded target of each master
  wb_map_pkg::tgt_id_t [N_MST-1:0] tgt;

  // Active request from each master, before steering
  logic [N_MST-1:0] mst_req;

  // Map one master address onto a target
  function automatic wb_map_pkg::tgt_id_t decode_tgt(input wb_bus_pkg::wb_adr_t adr);
    wb_map_pkg::wb_adr_view_u view;
    wb_map_pkg::tgt_id_t      id;
    view = adr;
    if (view.rgn.region == wb_map_pkg::REGION_MEM) begin
      // Flash memory window
      id = wb_map_pkg::TGT_MEM;
    end else if (view.pg.page == wb_map_pkg::PAGE_MEM_REG) begin
      // Flash register page lives on the memory target too
      id = wb_map_pkg::TGT_MEM;
    end else if ((view.pg.page == wb_map_pkg::PAGE_UART) ||
                 (view.pg.page == wb_map_pkg::PAGE_PINMUX)) begin
      id = wb_map_pkg::TGT_PERI;
    end else begin
      // Unmapped space falls back on s0
      id = wb_map_pkg::TGT_MEM;
    end
    return id;
  endfunction

  always_comb begin
    for (int i = 0; i < N_MST; i++) begin
      tgt[i] = decode_tgt(mst.adr[i]);
    end
  end

  // ----------------------------------------------------------------------
  // Request steering
  // ----------------------------------------------------------------------

  // Master is active while both cyc and stb are high
  assign mst_req = mst.cyc & mst.stb;

  always_comb begin
    for (int i = 0; i < N_MST; i++) begin
      req_mem_o[i]  = mst_req[i] & (tgt[i] == wb_map_pkg::TGT_MEM);
      req_peri_o[i] = mst_req[i] & (tgt[i] == wb_map_pkg::TGT_PERI);
    end
  end

  // ----------------------------------------------------------------------
  // Response select
  // ----------------------------------------------------------------------

  // Same decode picks the returning ack and data
  always_comb begin
    for (int i = 0; i < N_MST; i++) begin
      if (tgt[i] == wb_map_pkg::TGT_PERI) begin
        mst_ack_o[i] = ack_peri_i[i];
        mst_dat_o[i] = rdat_peri_i;
      end else begin
        mst_ack_o[i] = ack_mem_i[i];
        mst_dat_o[i] = rdat_mem_i;
      end
    end
  end

endmodule

// ==== wb_mst_if.sv ====
`timescale 1ns/1ps

// Request side of all masters, one slot per master
interface wb_mst_if #(
  parameter int N_MST = 3
);

  // ----------------------------------------------------------------------
  // Per-master request fields
  // ----------------------------------------------------------------------

  wb_bus_pkg::wb_adr_t  [N_MST-1:0] adr;
  wb_bus_pkg::wb_data_t [N_MST-1:0] wdat;
  wb_bus_pkg::wb_sel_t  [N_MST-1:0] sel;

  // Write enable, cycle and strobe, bit i belongs to master i
  logic [N_MST-1:0] we;
  logic [N_MST-1:0] cyc;
  logic [N_MST-1:0] stb;

  // Driven from the top-level master ports
  modport src (
    output adr, wdat, sel, we, cyc, stb
  );

  // Read by the router and the target ports
  modport snk (
    input adr, wdat, sel, we, cyc, stb
  );

endinterface

// ==== wb_map_pkg.sv ====
package wb_map_pkg;

  // ----------------------------------------------------------------------
  // Target identifiers
  // ----------------------------------------------------------------------

  // Memory target s0, peripheral target s1
  typedef enum logic [0:0] {
    TGT_MEM  = 1'b0,
    TGT_PERI = 1'b1
  } tgt_id_t;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------

  // Flash memory window 0x0000_0000 to 0x0FFF_FFFF
  localparam logic [3:0] REGION_MEM = 4'h0;

  // Flash controller register page
  localparam logic [15:0] PAGE_MEM_REG = 16'h1000;

  // UART block page and pin-mux page, both on the peripheral target
  localparam logic [15:0] PAGE_UART   = 16'h1001;
  localparam logic [15:0] PAGE_PINMUX = 16'h1002;

  // Region view: top nibble selects the large flash window
  typedef struct packed {
    logic [3:0]  region;
    logic [27:0] offset;
  } adr_region_t;

  // Page view: upper half word selects a 64 KB page
  typedef struct packed {
    logic [15:0] page;
    logic [15:0] offset;
  } adr_page_t;

  // Same 32-bit address seen either way
  typedef union packed {
    adr_region_t rgn;
    adr_page_t   pg;
  } wb_adr_view_u;

endpackage

// ==== wb_bus_pkg.sv ====
package wb_bus_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------

  // Data path of every master and slave
  localparam int DATA_W = 32;

  // Full byte address as issued by the masters
  localparam int ADR_W = 32;

  // One select bit per data byte
  localparam int SEL_W = DATA_W / 8;

  // ----------------------------------------------------------------------
  // Word types
  // ----------------------------------------------------------------------

  // Read or write data word
  typedef logic [DATA_W-1:0] wb_data_t;

  // Master address before any target truncation
  typedef logic [ADR_W-1:0] wb_adr_t;

  // Byte lane enables
  typedef logic [SEL_W-1:0] wb_sel_t;

endpackage
